// File: stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// raw sample width.
`define STREAM_SAMPLE_W 16

// sequence tag width, wraps at 256.
`define STREAM_SEQ_W 8

// storage entries, must be a power of two.
`define STREAM_FIFO_DEPTH 16

// data words per frame, 1 to FIFO depth.
`define STREAM_BURST 4

`endif

// File: stream_pkg.sv
`default_nettype none

`include "stream_consts.svh"

package stream_pkg;

   // stored FIFO word, tag above sample.
   typedef struct packed {
      logic [`STREAM_SEQ_W-1:0]    seq;
      logic [`STREAM_SAMPLE_W-1:0] data;
   } sample_word_t;

   typedef enum logic {
      KIND_HDR  = 1'b0,
      KIND_DATA = 1'b1
   } word_kind_e;

   // header payload carries the frame number in the low 16 bits.
   typedef struct packed {
      word_kind_e                                  kind;
      logic                                        last;
      logic [`STREAM_SEQ_W+`STREAM_SAMPLE_W-1:0]   payload;
   } frame_word_t;

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_HDR  = 2'd1,
      ST_DATA = 2'd2
   } builder_state_e;

endpackage

`default_nettype wire

// File: fifo_mem.sv
`default_nettype none

module fifo_mem #(
   parameter int WIDTH = 24,
   parameter int DEPTH = 16,
   parameter int BURST = 4
) (
   input  wire logic             clk_i,
   input  wire logic             srst_i,
   input  wire logic             wr_en_i,
   input  wire logic [WIDTH-1:0] wr_data_i,
   input  wire logic             rd_en_i,
   input  wire logic             held_i,
   output logic      [WIDTH-1:0] rd_data_o,
   output logic                  full_o,
   output logic                  empty_o,
   output logic                  burst_avail_o
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // registered read port, holds its value between reads.
   always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

   // pointers wrap naturally since depth is a power of two.
   always_ff @(posedge clk_i) begin
      if (srst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en_i) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en_i) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign full_o  = (count == CNT_W'(DEPTH));
   assign empty_o = (count == '0);

   // the word sitting in the prefetch stage still belongs to the next burst.
   assign burst_avail_o = (int'(count) + int'(held_i)) >= BURST;

   a_no_write_full: assert property (
      @(posedge clk_i) disable iff (srst_i) wr_en_i |-> !full_o
   );

   a_no_read_empty: assert property (
      @(posedge clk_i) disable iff (srst_i) rd_en_i |-> !empty_o
   );

endmodule

`default_nettype wire

// File: fifo.sv
`default_nettype none

`include "stream_consts.svh"

module fifo #(
   parameter int WIDTH = 24,
   parameter int BURST = 4
) (
   input  wire logic             clk_i,
   input  wire logic             srst_i,

   input  wire logic             in_val_i,
   input  wire logic [WIDTH-1:0] in_data_i,
   output logic                  in_rdy_o,

   output logic                  out_val_o,
   output logic      [WIDTH-1:0] out_data_o,
   input  wire logic             out_rdy_i,

   output logic                  burst_avail_o
);

   logic full;
   logic empty;
   logic wr_en;
   logic rd_en;
   logic held;

   assign in_rdy_o = ~full;
   assign wr_en    = in_val_i & ~full;

   // prefetch when nothing is held, or fetch the next word as the held one leaves.
   // under back-pressure no read is issued, so the held word stays.
   assign rd_en = ~empty & (~held | out_rdy_i);

   always_ff @(posedge clk_i) begin
      if (srst_i) begin
         held <= 1'b0;
      end else if (rd_en) begin
         held <= 1'b1;
      end else if (out_rdy_i) begin
         held <= 1'b0;
      end
   end

   assign out_val_o = held;

   // the read register of the storage is the prefetch stage, it only loads on rd_en.
   fifo_mem #(
      .WIDTH (WIDTH),
      .DEPTH (`STREAM_FIFO_DEPTH),
      .BURST (BURST)
   ) mem_inst (
      .clk_i         (clk_i),
      .srst_i        (srst_i),
      .wr_en_i       (wr_en),
      .wr_data_i     (in_data_i),
      .rd_en_i       (rd_en),
      .held_i        (held),
      .rd_data_o     (out_data_o),
      .full_o        (full),
      .empty_o       (empty),
      .burst_avail_o (burst_avail_o)
   );

   a_out_hold: assert property (
      @(posedge clk_i) disable iff (srst_i)
      (out_val_o && !out_rdy_i) |=> (out_val_o && $stable(out_data_o))
   );

endmodule

`default_nettype wire

// File: sample_tagger.sv
`default_nettype none

`include "stream_consts.svh"

module sample_tagger (
   input  wire logic                        clk_i,
   input  wire logic                        srst_i,
   input  wire logic                        sample_stb_i,
   input  wire logic [`STREAM_SAMPLE_W-1:0] sample_i,
   input  wire logic                        wr_rdy_i,
   output logic                             wr_val_o,
   output stream_pkg::sample_word_t         wr_word_o,
   output logic                             overflow_o
);

   logic [`STREAM_SEQ_W-1:0] seq;

   always_ff @(posedge clk_i) begin
      if (srst_i) begin
         seq      <= '0;
         wr_val_o <= 1'b0;
      end else begin
         wr_val_o <= sample_stb_i;
         // advances on drops too, so a lost sample leaves a gap.
         if (sample_stb_i) begin
            seq <= seq + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (sample_stb_i) begin
         wr_word_o.seq  <= seq;
         wr_word_o.data <= sample_i;
      end
   end

   // no retry. a word offered while the FIFO is full is lost.
   always_ff @(posedge clk_i) begin
      if (srst_i) begin
         overflow_o <= 1'b0;
      end else if (wr_val_o && !wr_rdy_i) begin
         overflow_o <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: frame_builder.sv
`default_nettype none

`include "stream_consts.svh"

module frame_builder (
   input  wire logic                      clk_i,
   input  wire logic                      srst_i,
   input  wire logic                      fifo_val_i,
   input  wire stream_pkg::sample_word_t  fifo_word_i,
   input  wire logic                      burst_avail_i,
   input  wire logic                      frame_rdy_i,
   output logic                           fifo_rdy_o,
   output logic                           frame_val_o,
   output stream_pkg::frame_word_t        frame_word_o
);

   localparam int CNT_W = $clog2(`STREAM_BURST + 1);

   stream_pkg::builder_state_e state;
   logic [15:0]                frame_cnt;
   logic [CNT_W-1:0]           data_cnt;
   logic                       last_data;
   logic                       hdr_take;
   logic                       data_take;

   assign last_data = (data_cnt == CNT_W'(`STREAM_BURST - 1));
   assign hdr_take  = (state == stream_pkg::ST_HDR) & frame_rdy_i;
   assign data_take = (state == stream_pkg::ST_DATA) & fifo_val_i & frame_rdy_i;

   // data words pass straight through, ready comes from the output side.
   assign fifo_rdy_o = (state == stream_pkg::ST_DATA) & frame_rdy_i;

   always_comb begin
      frame_val_o          = 1'b0;
      frame_word_o.kind    = stream_pkg::KIND_DATA;
      frame_word_o.last    = 1'b0;
      frame_word_o.payload = fifo_word_i;
      case (state)
         stream_pkg::ST_HDR: begin
            frame_val_o                = 1'b1;
            frame_word_o.kind          = stream_pkg::KIND_HDR;
            frame_word_o.payload       = '0;
            frame_word_o.payload[15:0] = frame_cnt;
         end
         stream_pkg::ST_DATA: begin
            frame_val_o       = fifo_val_i;
            frame_word_o.last = last_data;
         end
         default: begin
            frame_val_o = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (srst_i) begin
         state     <= stream_pkg::ST_IDLE;
         frame_cnt <= '0;
         data_cnt  <= '0;
      end else begin
         case (state)
            stream_pkg::ST_IDLE: begin
               if (burst_avail_i) begin
                  state <= stream_pkg::ST_HDR;
               end
            end
            stream_pkg::ST_HDR: begin
               if (hdr_take) begin
                  state     <= stream_pkg::ST_DATA;
                  data_cnt  <= '0;
                  frame_cnt <= frame_cnt + 1'b1;
               end
            end
            stream_pkg::ST_DATA: begin
               if (data_take) begin
                  if (last_data) begin
                     state    <= stream_pkg::ST_IDLE;
                     data_cnt <= '0;
                  end else begin
                     data_cnt <= data_cnt + 1'b1;
                  end
               end
            end
            default: begin
               state <= stream_pkg::ST_IDLE;
            end
         endcase
      end
   end

   a_cnt_in_burst: assert property (
      @(posedge clk_i) disable iff (srst_i)
      (state == stream_pkg::ST_DATA) |-> (data_cnt < CNT_W'(`STREAM_BURST))
   );

endmodule

`default_nettype wire

// File: stream_top.sv
`default_nettype none

`include "stream_consts.svh"

module stream_top (
   input  wire logic                        clk_i,
   input  wire logic                        srst_i,
   input  wire logic                        sample_stb_i,
   input  wire logic [`STREAM_SAMPLE_W-1:0] sample_i,
   input  wire logic                        frame_rdy_i,
   output logic                             frame_val_o,
   output stream_pkg::frame_word_t          frame_word_o,
   output logic                             overflow_o
);

   logic                     in_val;
   stream_pkg::sample_word_t in_data;
   logic                     in_rdy;
   logic                     out_val;
   stream_pkg::sample_word_t out_data;
   logic                     out_rdy;
   logic                     burst_avail;

   sample_tagger tagger_inst (
      .clk_i        (clk_i),
      .srst_i       (srst_i),
      .sample_stb_i (sample_stb_i),
      .sample_i     (sample_i),
      .wr_rdy_i     (in_rdy),
      .wr_val_o     (in_val),
      .wr_word_o    (in_data),
      .overflow_o   (overflow_o)
   );

   fifo #(
      .WIDTH ($bits(stream_pkg::sample_word_t)),
      .BURST (`STREAM_BURST)
   ) fifo_inst (
      .clk_i         (clk_i),
      .srst_i        (srst_i),
      .in_val_i      (in_val),
      .in_data_i     (in_data),
      .in_rdy_o      (in_rdy),
      .out_val_o     (out_val),
      .out_data_o    (out_data),
      .out_rdy_i     (out_rdy),
      .burst_avail_o (burst_avail)
   );

   frame_builder builder_inst (
      .clk_i         (clk_i),
      .srst_i        (srst_i),
      .fifo_val_i    (out_val),
      .fifo_word_i   (out_data),
      .burst_avail_i (burst_avail),
      .frame_rdy_i   (frame_rdy_i),
      .fifo_rdy_o    (out_rdy),
      .frame_val_o   (frame_val_o),
      .frame_word_o  (frame_word_o)
   );

endmodule

`default_nettype wire

// File: stream_tb.sv
`default_nettype none

`include "stream_consts.svh"

module stream_tb;

   localparam int RESET_CYCLES  = 16;
   localparam int IDLE_CYCLES   = 20;
   localparam int SPARSE_CYCLES = 600;
   localparam int MIXED_CYCLES  = 400;
   localparam int STALL_CYCLES  = 300;
   localparam int DRAIN_CYCLES  = 600;
   localparam int RUN_CYCLES    = RESET_CYCLES + IDLE_CYCLES + SPARSE_CYCLES +
                                  MIXED_CYCLES + STALL_CYCLES + DRAIN_CYCLES;
   // three times the nominal run length.
   localparam int WATCHDOG_TIME = RUN_CYCLES * 40 * 3;

   logic                          clk_i;
   logic                          srst_i;
   logic                          sample_stb_i;
   logic [`STREAM_SAMPLE_W-1:0]   sample_i;
   logic                          frame_rdy_i;
   logic                          frame_val_o;
   stream_pkg::frame_word_t       frame_word_o;
   logic                          overflow_o;

   logic [31:0]                   lfsr_state;
   stream_pkg::sample_word_t      ref_q [$];
   logic [`STREAM_SEQ_W-1:0]      seq_cnt;
   logic [15:0]                   frame_num;
   int                            data_idx;
   logic                          expect_hdr;
   logic                          any_strobe;
   logic                          gap_seen;
   int                            phase;
   int                            checks;
   int                            errors;
   int                            frames;
   logic                          prev_stall;
   stream_pkg::frame_word_t       prev_word;

   stream_top stream_top_inst (
      .clk_i        (clk_i),
      .srst_i       (srst_i),
      .sample_stb_i (sample_stb_i),
      .sample_i     (sample_i),
      .frame_rdy_i  (frame_rdy_i),
      .frame_val_o  (frame_val_o),
      .frame_word_o (frame_word_o),
      .overflow_o   (overflow_o)
   );

   always #20 clk_i = ~clk_i;

   // galois form of x^32 + x^22 + x^2 + x + 1 stepped once per bit.
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic expect_true(input logic cond, input string msg);
      checks++;
      assert (cond) else begin
         errors++;
         $display("CHECK FAILED at time %0t: %s", $time, msg);
      end
   endtask

   // phase 1 is sparse and stall free.
   // phase 3 holds the output off for long stretches.
   task automatic run_phase(input int id, input int cycles);
      logic                     stb;
      logic                     rdy;
      logic [31:0]              r;
      stream_pkg::sample_word_t entry;
      phase = id;
      repeat (cycles) begin
         @(posedge clk_i);
         #2;
         case (id)
            0: begin
               stb = 1'b0;
               rdy = 1'b1;
            end
            2: begin
               stb = (random_bits(2) == 32'd3);
               rdy = (random_bits(1) == 32'd1);
            end
            3: begin
               stb = (random_bits(2) != 32'd0);
               rdy = (random_bits(4) == 32'd15);
            end
            default: begin
               stb = (random_bits(3) == 32'd7);
               rdy = 1'b1;
            end
         endcase
         sample_stb_i = stb;
         frame_rdy_i  = rdy;
         if (stb) begin
            r          = random_bits(16);
            sample_i   = r[15:0];
            entry.seq  = seq_cnt;
            entry.data = r[15:0];
            ref_q.push_back(entry);
            seq_cnt    = seq_cnt + 8'd1;
            any_strobe = 1'b1;
         end
      end
   endtask

   task automatic take_word();
      stream_pkg::frame_word_t  w;
      stream_pkg::sample_word_t got;
      stream_pkg::sample_word_t exp;
      int                       skipped;
      w = frame_word_o;
      if (expect_hdr) begin
         expect_true(w.kind == stream_pkg::KIND_HDR, "data word where a header was due");
         expect_true(!w.last, "last set on a header");
         expect_true(w.payload == {8'h00, frame_num},
                     $sformatf("header number %0h, expected %0h", w.payload, frame_num));
         frame_num  = frame_num + 16'd1;
         expect_hdr = 1'b0;
         data_idx   = 0;
      end else begin
         expect_true(w.kind == stream_pkg::KIND_DATA, "header inside a frame");
         expect_true(w.last == (data_idx == `STREAM_BURST - 1),
                     $sformatf("last flag %0b on data word %0d", w.last, data_idx));
         got = w.payload;
         skipped = 0;
         // entries passed over here were dropped at the input.
         while (ref_q.size() > 0 && ref_q[0].seq != got.seq) begin
            void'(ref_q.pop_front());
            skipped++;
         end
         if (ref_q.size() == 0) begin
            expect_true(1'b0, $sformatf("seq %0d was never strobed or came out of order",
                                        got.seq));
         end else begin
            exp = ref_q.pop_front();
            expect_true(got.data == exp.data,
                        $sformatf("seq %0d data %h, expected %h", got.seq, got.data, exp.data));
         end
         expect_true(skipped < 128, $sformatf("seq %0d went backwards", got.seq));
         if (skipped > 0) begin
            gap_seen = 1'b1;
            expect_true(overflow_o, $sformatf("gap before seq %0d but no overflow", got.seq));
         end
         data_idx++;
         if (data_idx == `STREAM_BURST) begin
            expect_hdr = 1'b1;
            frames++;
         end
      end
   endtask

   // outputs settle well before the falling edge.
   always @(negedge clk_i) begin
      if (srst_i) begin
         prev_stall = 1'b0;
      end else begin
         if (!any_strobe) begin
            expect_true(!frame_val_o && !overflow_o, "output active before the first sample");
         end
         if (phase == 1) begin
            expect_true(!overflow_o, "overflow in the sparse stall-free phase");
         end
         if (prev_stall) begin
            expect_true(frame_val_o && (frame_word_o == prev_word),
                        "output word changed while stalled");
         end
         if (frame_val_o && frame_rdy_i) begin
            take_word();
         end
         prev_stall = frame_val_o && !frame_rdy_i;
         prev_word  = frame_word_o;
      end
   end

   initial begin
      #(WATCHDOG_TIME);
      $display("watchdog expired before the run completed");
      $display("Test failed");
      $finish;
   end

   initial begin
      srst_i       = 1'b1;
      clk_i        = 1'b0;
      sample_stb_i = 1'b0;
      sample_i     = '0;
      frame_rdy_i  = 1'b0;
      lfsr_state   = 32'h026f_acf4;
      seq_cnt      = '0;
      frame_num    = '0;
      data_idx     = 0;
      expect_hdr   = 1'b1;
      any_strobe   = 1'b0;
      gap_seen     = 1'b0;
      phase        = 0;
      checks       = 0;
      errors       = 0;
      frames       = 0;
      prev_stall   = 1'b0;
      prev_word    = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      srst_i = 1'b0;
      run_phase(0, IDLE_CYCLES);
      run_phase(1, SPARSE_CYCLES);
      run_phase(2, MIXED_CYCLES);
      run_phase(3, STALL_CYCLES);
      run_phase(4, DRAIN_CYCLES);
      @(negedge clk_i);
      #1;
      expect_true(frames > 0, "no complete frame was received");
      expect_true(gap_seen, "no dropped sample showed up at the output");
      expect_true(overflow_o == gap_seen, "overflow flag disagrees with the observed gaps");
      $display("summary: %0d checks, %0d errors, %0d frames", checks, errors, frames);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
stream_pkg.sv
fifo_mem.sv
fifo.sv
sample_tagger.sv
frame_builder.sv
stream_top.sv
stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir

if ! verilator --binary --timing --assert -f files.f --top-module stream_tb -Mdir obj_dir; then
   echo "Verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vstream_tb > "$LOG" 2>&1; then
   cat "$LOG"
   echo "simulation exited with an error"
   exit 1
fi

cat "$LOG"

if grep -qx "Test passed" "$LOG"; then
   exit 0
else
   echo "pass message not found in $LOG"
   exit 1
fi
